// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module boot_loader_tb --Mdir obj_dir -f boot_loader.f
	@out="$$(./obj_dir/Vboot_loader_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: boot_loader.f
hdl/boot_pkg.sv
hdl/boot_sequencer.sv
hdl/block_copier.sv
hdl/mem_read_arbiter.sv
hdl/boot_loader.sv
verification/boot_models.sv
verification/boot_loader_tb.sv

// File: hdl/block_copier.sv
module block_copier #(
  parameter int addr_w = 10,
  parameter int base   = 0
) (
  input  logic                clock,
  input  logic                ir_rst,
  input  boot_pkg::copy_job_t job,
  input  logic                job_req,
  output logic                job_ack,
  output logic                busy,
  output logic                rd_req,
  output boot_pkg::mem_addr_t rd_addr,
  input  logic                rd_ack,
  input  boot_pkg::data_t     rd_data,
  output logic                we,
  output logic [addr_w-1:0]   addr,
  output boot_pkg::data_t     wdata
);

  import boot_pkg::*;

  typedef enum logic [1:0] {
    cp_idle,
    cp_read,
    cp_release
  } cp_state_t;

  cp_state_t         state;
  mem_addr_t         src_ptr;
  word_count_t       remaining;
  logic [addr_w-1:0] tgt_ptr;   // Runs on across jobs
  logic              job_take;

  assign job_take = (state == cp_idle) && job_req && !job_ack;

  // Still busy until the job handshake has closed
  assign busy    = (state != cp_idle) || job_ack;
  assign rd_addr = src_ptr;
  assign addr    = tgt_ptr;

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      job_ack <= 1'b0;
    end else if (job_ack && !job_req) begin
      job_ack <= 1'b0;
    end else if (job_take) begin
      job_ack <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      state   <= cp_idle;
      rd_req  <= 1'b0;
      we      <= 1'b0;
      tgt_ptr <= addr_w'(base);
    end else begin
      we <= 1'b0;
      if (we) begin
        tgt_ptr <= tgt_ptr + 1'b1; // Wraps at addr_w
      end
      case (state)
        cp_idle: begin
          if (job_take && job.len != '0) begin
            rd_req <= 1'b1;
            state  <= cp_read;
          end
        end

        cp_read: begin
          if (rd_ack) begin
            rd_req <= 1'b0;
            we     <= 1'b1;
            state  <= cp_release;
          end
        end

        // Wait for the arbiter to drop ack before the next word
        cp_release: begin
          if (!rd_ack) begin
            if (remaining == '0) begin
              state <= cp_idle;
            end else begin
              rd_req <= 1'b1;
              state  <= cp_read;
            end
          end
        end

        default: begin
          state <= cp_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (job_take) begin
      src_ptr   <= job.src;
      remaining <= job.len;
    end else if (state == cp_read && rd_ack) begin
      src_ptr   <= src_ptr + 1'b1;
      remaining <= remaining - 1'b1;
      wdata     <= rd_data;
    end
  end

endmodule

// File: hdl/boot_loader.sv
module boot_loader (
  input  logic                           clock,
  input  logic                           ir_rst,
  input  logic                           system_enable,
  output logic                           rom_en,
  output boot_pkg::rom_addr_t            rom_addr,
  input  boot_pkg::boot_cmd_t            rom_data,
  output logic                           mem_req,
  output boot_pkg::mem_addr_t            mem_addr,
  input  logic                           mem_ack,
  input  boot_pkg::data_t                mem_data,
  output logic                           im_we,
  output logic [boot_pkg::im_addr_w-1:0] im_addr,
  output boot_pkg::data_t                im_wdata,
  output logic                           dm_we,
  output logic [boot_pkg::dm_addr_w-1:0] dm_addr,
  output boot_pkg::data_t                dm_wdata,
  output logic                           boot_done
);

  import boot_pkg::*;

  // Sequencer to copiers
  copy_job_t im_job;
  copy_job_t dm_job;
  logic      im_job_req;
  logic      im_job_ack;
  logic      im_busy;
  logic      dm_job_req;
  logic      dm_job_ack;
  logic      dm_busy;

  // Copiers to arbiter
  logic      im_rd_req;
  mem_addr_t im_rd_addr;
  logic      im_rd_ack;
  data_t     im_rd_data;
  logic      dm_rd_req;
  mem_addr_t dm_rd_addr;
  logic      dm_rd_ack;
  data_t     dm_rd_data;

  boot_sequencer sequencer (
    .clock         (clock),
    .ir_rst        (ir_rst),
    .system_enable (system_enable),
    .rom_en        (rom_en),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data),
    .im_job        (im_job),
    .im_job_req    (im_job_req),
    .im_job_ack    (im_job_ack),
    .im_busy       (im_busy),
    .dm_job        (dm_job),
    .dm_job_req    (dm_job_req),
    .dm_job_ack    (dm_job_ack),
    .dm_busy       (dm_busy),
    .boot_done     (boot_done)
  );

  block_copier #(
    .addr_w (im_addr_w),
    .base   (im_base)
  ) im_copier (
    .clock   (clock),
    .ir_rst  (ir_rst),
    .job     (im_job),
    .job_req (im_job_req),
    .job_ack (im_job_ack),
    .busy    (im_busy),
    .rd_req  (im_rd_req),
    .rd_addr (im_rd_addr),
    .rd_ack  (im_rd_ack),
    .rd_data (im_rd_data),
    .we      (im_we),
    .addr    (im_addr),
    .wdata   (im_wdata)
  );

  block_copier #(
    .addr_w (dm_addr_w),
    .base   (dm_base)
  ) dm_copier (
    .clock   (clock),
    .ir_rst  (ir_rst),
    .job     (dm_job),
    .job_req (dm_job_req),
    .job_ack (dm_job_ack),
    .busy    (dm_busy),
    .rd_req  (dm_rd_req),
    .rd_addr (dm_rd_addr),
    .rd_ack  (dm_rd_ack),
    .rd_data (dm_rd_data),
    .we      (dm_we),
    .addr    (dm_addr),
    .wdata   (dm_wdata)
  );

  mem_read_arbiter arbiter (
    .clock      (clock),
    .ir_rst     (ir_rst),
    .im_rd_req  (im_rd_req),
    .im_rd_addr (im_rd_addr),
    .im_rd_ack  (im_rd_ack),
    .im_rd_data (im_rd_data),
    .dm_rd_req  (dm_rd_req),
    .dm_rd_addr (dm_rd_addr),
    .dm_rd_ack  (dm_rd_ack),
    .dm_rd_data (dm_rd_data),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_data   (mem_data)
  );

endmodule

// File: hdl/boot_pkg.sv
package boot_pkg;

  // Target memory geometry
  localparam int im_addr_w = 10;
  localparam int dm_addr_w = 12;
  localparam int im_base   = 0;
  localparam int dm_base   = 0;

  typedef logic [7:0]  rom_addr_t;
  typedef logic [15:0] mem_addr_t;
  typedef logic [15:0] word_count_t;
  typedef logic [31:0] data_t;

  // One boot ROM entry, bit 35 first
  typedef struct packed {
    logic        skip;
    logic        enable;
    logic        sel;    // 0 IM, 1 DM
    logic        rsvd;
    mem_addr_t   src;
    word_count_t len;
  } boot_cmd_t;

  // What a copier needs from a command
  typedef struct packed {
    mem_addr_t   src;
    word_count_t len;
  } copy_job_t;

  typedef enum logic [2:0] {
    idle,
    fetch,
    decode,
    dispatch,
    drain,
    done
  } seq_state_t;

endpackage

// File: hdl/boot_sequencer.sv
module boot_sequencer (
  input  logic                clock,
  input  logic                ir_rst,
  input  logic                system_enable,
  output logic                rom_en,
  output boot_pkg::rom_addr_t rom_addr,
  input  boot_pkg::boot_cmd_t rom_data,
  output boot_pkg::copy_job_t im_job,
  output logic                im_job_req,
  input  logic                im_job_ack,
  input  logic                im_busy,
  output boot_pkg::copy_job_t dm_job,
  output logic                dm_job_req,
  input  logic                dm_job_ack,
  input  logic                dm_busy,
  output logic                boot_done
);

  import boot_pkg::*;

  seq_state_t state;
  rom_addr_t  rom_ptr;
  copy_job_t  job_q;
  logic       sel_q;
  logic       cmd_end;
  logic       cmd_ignore;
  logic       tgt_ack;

  assign rom_en   = (state == fetch);
  assign rom_addr = rom_ptr;

  // Same job goes to both ports and req picks the copier
  assign im_job = job_q;
  assign dm_job = job_q;

  assign cmd_end    = (rom_data == '0);
  assign cmd_ignore = rom_data.skip || !rom_data.enable;

  assign tgt_ack = sel_q ? dm_job_ack : im_job_ack;

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      state      <= idle;
      rom_ptr    <= '0;
      sel_q      <= 1'b0;
      im_job_req <= 1'b0;
      dm_job_req <= 1'b0;
      boot_done  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (system_enable) begin
            state <= fetch;
          end
        end

        fetch: begin
          state <= decode; // ROM data shows up next cycle
        end

        // Previous ack has already dropped by the time we get here
        decode: begin
          rom_ptr <= rom_ptr + 1'b1;
          if (cmd_end) begin
            state <= drain;
          end else if (cmd_ignore) begin
            state <= fetch;
          end else begin
            sel_q      <= rom_data.sel;
            state      <= dispatch;
            im_job_req <= !rom_data.sel;
            dm_job_req <= rom_data.sel;
          end
        end

        // Copier acks only once idle so a busy copier stalls us here
        dispatch: begin
          if (tgt_ack) begin
            im_job_req <= 1'b0;
            dm_job_req <= 1'b0;
            state      <= fetch;
          end
        end

        drain: begin
          if (!im_busy && !dm_busy) begin
            boot_done <= 1'b1;
            state     <= done;
          end
        end

        done: begin
          // boot_done held until reset
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == decode) begin
      job_q.src <= rom_data.src;
      job_q.len <= rom_data.len;
    end
  end

endmodule

// File: hdl/mem_read_arbiter.sv
module mem_read_arbiter (
  input  logic                clock,
  input  logic                ir_rst,
  input  logic                im_rd_req,
  input  boot_pkg::mem_addr_t im_rd_addr,
  output logic                im_rd_ack,
  output boot_pkg::data_t     im_rd_data,
  input  logic                dm_rd_req,
  input  boot_pkg::mem_addr_t dm_rd_addr,
  output logic                dm_rd_ack,
  output boot_pkg::data_t     dm_rd_data,
  output logic                mem_req,
  output boot_pkg::mem_addr_t mem_addr,
  input  logic                mem_ack,
  input  boot_pkg::data_t     mem_data
);

  import boot_pkg::*;

  typedef enum logic [1:0] {
    arb_idle,
    arb_fetch,
    arb_finish
  } arb_state_t;

  arb_state_t state;
  logic       grant_dm;   // Owner of the transfer in flight
  logic       prefer_dm;  // Who wins the next tie
  logic       rd_ack;
  data_t      data_q;
  logic       pick_im;
  logic       pick_dm;
  logic       owner_req;

  assign pick_im   = im_rd_req && (!dm_rd_req || !prefer_dm);
  assign pick_dm   = dm_rd_req && !pick_im;
  assign owner_req = grant_dm ? dm_rd_req : im_rd_req;

  assign im_rd_ack  = rd_ack && !grant_dm;
  assign dm_rd_ack  = rd_ack && grant_dm;
  assign im_rd_data = data_q;
  assign dm_rd_data = data_q;

  always_ff @(posedge clock) begin
    if (ir_rst) begin
      state     <= arb_idle;
      grant_dm  <= 1'b0;
      prefer_dm <= 1'b0; // IM first after reset
      rd_ack    <= 1'b0;
      mem_req   <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (pick_im || pick_dm) begin
            grant_dm  <= pick_dm;
            prefer_dm <= pick_im;
            mem_req   <= 1'b1;
            state     <= arb_fetch;
          end
        end

        arb_fetch: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            rd_ack  <= 1'b1;
            state   <= arb_finish;
          end
        end

        // Both handshakes must be back at rest
        arb_finish: begin
          if (!mem_ack && !owner_req) begin
            rd_ack <= 1'b0;
            state  <= arb_idle;
          end
        end

        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == arb_idle && (pick_im || pick_dm)) begin
      mem_addr <= pick_im ? im_rd_addr : dm_rd_addr;
    end
    if (state == arb_fetch && mem_ack) begin
      data_q <= mem_data;
    end
  end

endmodule

// File: verification/boot_loader_tb.sv
module boot_loader_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import boot_pkg::*;

  logic                 clock;
  logic                 ir_rst;
  logic                 system_enable;
  logic                 rom_en;
  rom_addr_t            rom_addr;
  boot_cmd_t            rom_data;
  logic                 mem_req;
  mem_addr_t            mem_addr;
  logic                 mem_ack;
  data_t                mem_data;
  logic                 im_we;
  logic [im_addr_w-1:0] im_addr;
  data_t                im_wdata;
  logic                 dm_we;
  logic [dm_addr_w-1:0] dm_addr;
  data_t                dm_wdata;
  logic                 boot_done;

  logic                 rom_clear;
  logic                 rom_we;
  rom_addr_t            rom_waddr;
  boot_cmd_t            rom_wdata;
  logic [2:0]           ack_delay;
  logic                 random_delay;
  logic [31:0]          delay_bits;
  logic [31:0]          lfsr_state = 32'd86075;

  boot_cmd_t   rom_cmds[$];
  logic [31:0] im_got_addr[$];
  data_t       im_got_data[$];
  logic [31:0] dm_got_addr[$];
  data_t       dm_got_data[$];
  logic [31:0] exp_im_addr[$];
  data_t       exp_im_data[$];
  logic [31:0] exp_dm_addr[$];
  data_t       exp_dm_data[$];

  boot_loader boot_loader_inst (
    .clock         (clock),
    .ir_rst        (ir_rst),
    .system_enable (system_enable),
    .rom_en        (rom_en),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data),
    .mem_req       (mem_req),
    .mem_addr      (mem_addr),
    .mem_ack       (mem_ack),
    .mem_data      (mem_data),
    .im_we         (im_we),
    .im_addr       (im_addr),
    .im_wdata      (im_wdata),
    .dm_we         (dm_we),
    .dm_addr       (dm_addr),
    .dm_wdata      (dm_wdata),
    .boot_done     (boot_done)
  );

  boot_rom_model boot_rom (
    .clock    (clock),
    .clear    (rom_clear),
    .we       (rom_we),
    .waddr    (rom_waddr),
    .wdata    (rom_wdata),
    .rom_en   (rom_en),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  main_mem_model main_mem (
    .clock     (clock),
    .ir_rst    (ir_rst),
    .ack_delay (ack_delay),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_data  (mem_data)
  );

  always #10 clock = ~clock;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // Main memory contents as the model serves them
  function automatic data_t expected_word(input mem_addr_t a);
    return {~a, a ^ 16'h3c5a};
  endfunction

  function automatic boot_cmd_t make_cmd(input logic sel, input mem_addr_t src,
                                         input word_count_t len);
    boot_cmd_t c;
    c.skip   = 1'b0;
    c.enable = 1'b1;
    c.sel    = sel;
    c.rsvd   = 1'b0;
    c.src    = src;
    c.len    = len;
    return c;
  endfunction

  function automatic boot_cmd_t im_cmd(input mem_addr_t src, input word_count_t len);
    return make_cmd(1'b0, src, len);
  endfunction

  function automatic boot_cmd_t dm_cmd(input mem_addr_t src, input word_count_t len);
    return make_cmd(1'b1, src, len);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at time %0t: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // New delay each cycle for the memory model
  always @(negedge clock) begin
    if (random_delay) begin
      take_random_bits(3, delay_bits);
      ack_delay = delay_bits[2:0];
    end else begin
      ack_delay = 3'd1;
    end
  end

  always @(negedge clock) begin
    if (!ir_rst && im_we) begin
      im_got_addr.push_back(32'(im_addr));
      im_got_data.push_back(im_wdata);
    end
    if (!ir_rst && dm_we) begin
      dm_got_addr.push_back(32'(dm_addr));
      dm_got_data.push_back(dm_wdata);
    end
  end

  task automatic run_boot(input logic use_random);
    int cycles;
    @(posedge clock);
    #1;
    system_enable = 1'b0;
    random_delay  = use_random;
    rom_clear     = 1'b1;
    @(posedge clock);
    #1;
    rom_clear = 1'b0;
    foreach (rom_cmds[i]) begin
      rom_we    = 1'b1;
      rom_waddr = rom_addr_t'(i);
      rom_wdata = rom_cmds[i];
      @(posedge clock);
      #1;
    end
    rom_we = 1'b0;
    ir_rst = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    ir_rst = 1'b0;
    im_got_addr.delete();
    im_got_data.delete();
    dm_got_addr.delete();
    dm_got_data.delete();
    check_value("rom_en after reset", 32'(rom_en), 32'd0);
    check_value("mem_req after reset", 32'(mem_req), 32'd0);
    check_value("im_we after reset", 32'(im_we), 32'd0);
    check_value("dm_we after reset", 32'(dm_we), 32'd0);
    check_value("boot_done after reset", 32'(boot_done), 32'd0);
    system_enable = 1'b1;
    cycles = 0;
    while (!boot_done && cycles < 20000) begin
      @(negedge clock);
      cycles++;
    end
    if (!boot_done) begin
      abort_run("boot_done did not rise within 20000 cycles");
    end
    repeat (10) @(negedge clock); // Catch stray writes after boot_done
  endtask

  // Expected writes from the ROM image
  task automatic expect_from_rom();
    logic [im_addr_w-1:0] im_next;
    logic [dm_addr_w-1:0] dm_next;
    mem_addr_t            src;
    logic                 ended;
    exp_im_addr.delete();
    exp_im_data.delete();
    exp_dm_addr.delete();
    exp_dm_data.delete();
    im_next = im_addr_w'(im_base);
    dm_next = dm_addr_w'(dm_base);
    ended   = 1'b0;
    foreach (rom_cmds[i]) begin
      if (rom_cmds[i] == '0) begin
        ended = 1'b1;
      end
      if (!ended && !rom_cmds[i].skip && rom_cmds[i].enable) begin
        src = rom_cmds[i].src;
        for (int j = 0; j < int'(rom_cmds[i].len); j++) begin
          if (rom_cmds[i].sel) begin
            exp_dm_addr.push_back(32'(dm_next));
            exp_dm_data.push_back(expected_word(src));
            dm_next = dm_next + dm_addr_w'(1);
          end else begin
            exp_im_addr.push_back(32'(im_next));
            exp_im_data.push_back(expected_word(src));
            im_next = im_next + im_addr_w'(1);
          end
          src = src + 16'd1;
        end
      end
    end
  endtask

  task automatic compare_writes();
    expect_from_rom();
    check_value("im write count", im_got_addr.size(), exp_im_addr.size());
    check_value("dm write count", dm_got_addr.size(), exp_dm_addr.size());
    foreach (exp_im_addr[i]) begin
      check_value($sformatf("im_addr[%0d]", i), im_got_addr[i], exp_im_addr[i]);
      check_value($sformatf("im_wdata[%0d]", i), im_got_data[i], exp_im_data[i]);
    end
    foreach (exp_dm_addr[i]) begin
      check_value($sformatf("dm_addr[%0d]", i), dm_got_addr[i], exp_dm_addr[i]);
      check_value($sformatf("dm_wdata[%0d]", i), dm_got_data[i], exp_dm_data[i]);
    end
  endtask

  task automatic single_im_test();
    rom_cmds.delete();
    rom_cmds.push_back(im_cmd(16'h0100, 16'd5));
    rom_cmds.push_back('0);
    run_boot(1'b0);
    compare_writes();
  endtask

  task automatic dm_then_im_test();
    rom_cmds.delete();
    rom_cmds.push_back(dm_cmd(16'h0200, 16'd7));
    rom_cmds.push_back(im_cmd(16'h0300, 16'd3));
    rom_cmds.push_back('0);
    run_boot(1'b0);
    compare_writes();
  endtask

  task automatic skipped_cmds_test();
    boot_cmd_t c;
    rom_cmds.delete();
    c = im_cmd(16'h0400, 16'd4);
    c.skip = 1'b1;
    rom_cmds.push_back(c);
    c = dm_cmd(16'h0500, 16'd4);
    c.enable = 1'b0;
    rom_cmds.push_back(c);
    c = im_cmd(16'h0600, 16'd3);
    c.rsvd = 1'b1; // Ignored bit
    rom_cmds.push_back(c);
    c = dm_cmd(16'h0700, 16'd2);
    c.skip = 1'b1;
    rom_cmds.push_back(c);
    rom_cmds.push_back(dm_cmd(16'h0800, 16'd4));
    rom_cmds.push_back('0);
    run_boot(1'b0);
    compare_writes();
  endtask

  task automatic end_word_test();
    rom_cmds.delete();
    rom_cmds.push_back(im_cmd(16'h0900, 16'd4));
    rom_cmds.push_back('0);
    rom_cmds.push_back(dm_cmd(16'h0a00, 16'd6));
    rom_cmds.push_back(im_cmd(16'h0b00, 16'd2));
    run_boot(1'b0);
    for (int i = 0; i < 30; i++) begin
      @(negedge clock);
      check_value("boot_done held", 32'(boot_done), 32'd1);
      check_value("mem_req after end word", 32'(mem_req), 32'd0);
    end
    compare_writes();
  endtask

  task automatic interleaved_random_test();
    rom_cmds.delete();
    rom_cmds.push_back(im_cmd(16'h1000, 16'd9));
    rom_cmds.push_back(im_cmd(16'h1100, 16'd4)); // Waits for a busy IM copier
    rom_cmds.push_back(dm_cmd(16'h2000, 16'd12));
    rom_cmds.push_back(dm_cmd(16'h2100, 16'd3));
    rom_cmds.push_back(im_cmd(16'hfffd, 16'd6)); // Source wraps past 0xffff
    rom_cmds.push_back(dm_cmd(16'h2200, 16'd5));
    rom_cmds.push_back('0);
    run_boot(1'b1);
    compare_writes();
  endtask

  task automatic zero_length_test();
    rom_cmds.delete();
    rom_cmds.push_back(im_cmd(16'h3000, 16'd0));
    rom_cmds.push_back(dm_cmd(16'h3100, 16'd2));
    rom_cmds.push_back(dm_cmd(16'h3200, 16'd0));
    rom_cmds.push_back(im_cmd(16'h3300, 16'd1));
    rom_cmds.push_back('0);
    run_boot(1'b0);
    compare_writes();
  endtask

  initial begin
    clock         = 1'b0;
    ir_rst        = 1'b1;
    system_enable = 1'b0;
    rom_clear     = 1'b0;
    rom_we        = 1'b0;
    rom_waddr     = '0;
    rom_wdata     = '0;
    random_delay  = 1'b0;
    ack_delay     = 3'd1;
    single_im_test();
    dm_then_im_test();
    skipped_cmds_test();
    end_word_test();
    interleaved_random_test();
    zero_length_test();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verification/boot_models.sv
module boot_rom_model (
  input  logic                clock,
  input  logic                clear,
  input  logic                we,
  input  boot_pkg::rom_addr_t waddr,
  input  boot_pkg::boot_cmd_t wdata,
  input  logic                rom_en,
  input  boot_pkg::rom_addr_t rom_addr,
  output boot_pkg::boot_cmd_t rom_data
);

  timeunit 1ns;
  timeprecision 1ps;

  import boot_pkg::*;

  boot_cmd_t words [256];

  always @(posedge clock) begin
    if (clear) begin
      for (int i = 0; i < 256; i++) begin
        words[i] <= '0; // Empty entries read as the end word
      end
    end else if (we) begin
      words[waddr] <= wdata;
    end
    if (rom_en) begin
      rom_data <= #1 words[rom_addr];
    end
  end

endmodule

module main_mem_model (
  input  logic                clock,
  input  logic                ir_rst,
  input  logic [2:0]          ack_delay,
  input  logic                mem_req,
  input  boot_pkg::mem_addr_t mem_addr,
  output logic                mem_ack,
  output boot_pkg::data_t     mem_data
);

  timeunit 1ns;
  timeprecision 1ps;

  import boot_pkg::*;

  logic [2:0] wait_cnt;

  function automatic data_t word_at(input mem_addr_t a);
    return {~a, a ^ 16'h3c5a};
  endfunction

  always @(posedge clock) begin
    if (ir_rst) begin
      mem_ack  <= #1 1'b0;
      mem_data <= #1 '0;
      wait_cnt <= 3'd0;
    end else if (!mem_ack && mem_req) begin
      if (wait_cnt >= ack_delay) begin // Delay is re-read every cycle
        mem_ack  <= #1 1'b1;
        mem_data <= #1 word_at(mem_addr);
        wait_cnt <= 3'd0;
      end else begin
        wait_cnt <= wait_cnt + 3'd1;
      end
    end else if (mem_ack && !mem_req) begin
      mem_ack <= #1 1'b0;
    end
  end

endmodule
